// ==== arcade_mem.f ====
logic/arcade_pkg.sv
logic/download_ctrl.sv
logic/mem_arbiter.sv
logic/rom_fetch.sv
logic/rom_store.sv
logic/prom_bank.sv
logic/arcade_mem_top.sv
testbench/tb_arcade_mem.sv

// ==== Bender.yml ====
package:
  name: arcade_mem

sources:
  - logic/arcade_pkg.sv
  - logic/download_ctrl.sv
  - logic/mem_arbiter.sv
  - logic/rom_fetch.sv
  - logic/rom_store.sv
  - logic/prom_bank.sv
  - logic/arcade_mem_top.sv
  - target: test
    files:
      - testbench/tb_arcade_mem.sv

// ==== testbench/tb_arcade_mem.sv ====
// Directed testbench for the ROM loading subsystem, run as the simulation top with the default setup
`timescale 1ns/1ns
module tb_arcade_mem import arcade_pkg::*; ();

// Mirrors the top level defaults
localparam rom_addr_t PROM_START      = 16'h1000;
localparam int        NUM_PROMS       = 4;
localparam int        SOFT_RST_CYCLES = 255;
localparam rom_addr_t MEM_BASE        = 16'h0040;
localparam rom_addr_t STREAM_BASE     = 16'h0800;
localparam int        WAIT_LIMIT      = 64;

logic       clk;
logic       rst;
logic       downloading;
logic       romload_wr;
rom_addr_t  romload_addr;
rom_data_t  romload_data;
logic       rst_req;
logic       fetch_req;
rom_addr_t  fetch_addr;
rom_data_t  fetch_data;
logic       fetch_ok;
logic       fetch_busy;
prom_sel_t  prom_sel;
prom_addr_t prom_addr;
prom_data_t prom_data;
logic       soft_rst;

int          errors;
int          timeouts;
logic [31:0] rand_state;
rom_data_t   exp_mem [4096];           // Words the download put into memory
prom_data_t  exp_prom [NUM_PROMS][256];

arcade_mem_top dut0 (
    .clk          ( clk          ),
    .rst          ( rst          ),
    .downloading  ( downloading  ),
    .romload_wr   ( romload_wr   ),
    .romload_addr ( romload_addr ),
    .romload_data ( romload_data ),
    .rst_req      ( rst_req      ),
    .soft_rst     ( soft_rst     ),
    .fetch_req    ( fetch_req    ),
    .fetch_addr   ( fetch_addr   ),
    .fetch_data   ( fetch_data   ),
    .fetch_ok     ( fetch_ok     ),
    .fetch_busy   ( fetch_busy   ),
    .prom_sel     ( prom_sel     ),
    .prom_addr    ( prom_addr    ),
    .prom_data    ( prom_data    )
);

always #2 clk = ~clk;   // 4 ns period

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

function automatic rom_data_t next_word();
    rand_state = xorshift32(rand_state);
    return rand_state[15:0];
endfunction

task automatic report_mismatch(input string msg);
    $display("Error at %0t ns: %s", $time, msg);
    errors++;
endtask

task automatic report_timeout(input string what);
    $display("Gave up waiting for %s at %0t ns", what, $time);
    timeouts++;
endtask

// Every task starts and ends 1 ns after a rising edge
task automatic next_cycle();
    @(posedge clk);
    #1;
endtask

task automatic drive_reset();
    rst = 1'b1;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
endtask

task automatic start_download();
    downloading = 1'b1;
    next_cycle();
endtask

// Two edges let the last memory write land
task automatic end_download();
    repeat (2) next_cycle();
    downloading = 1'b0;
endtask

task automatic write_word(input rom_addr_t addr, input rom_data_t data);
    romload_wr   = 1'b1;
    romload_addr = addr;
    romload_data = data;
    next_cycle();
    romload_wr   = 1'b0;
endtask

task automatic fetch_word(input rom_addr_t addr, output rom_data_t data,
                          output int cycles, output logic ok);
    int waited;
    waited = 0;
    ok     = 1'b0;
    cycles = 0;
    data   = '0;
    while (fetch_busy && waited < WAIT_LIMIT) begin
        next_cycle();
        waited++;
    end
    if (fetch_busy) begin
        report_timeout("fetch_busy to fall");
    end else begin
        fetch_req  = 1'b1;
        fetch_addr = addr;
        do begin
            next_cycle();
            fetch_req = 1'b0;
            cycles++;
            if (cycles == 1 && fetch_busy !== 1'b1) begin
                report_mismatch($sformatf("fetch_busy low the cycle after fetch 0x%h", addr));
            end
        end while (!fetch_ok && cycles < WAIT_LIMIT);
        if (!fetch_ok) begin
            report_timeout($sformatf("fetch_ok on address 0x%h", addr));
        end else begin
            ok   = 1'b1;
            data = fetch_data;
            if (fetch_busy) begin
                report_mismatch("fetch_busy still high together with fetch_ok");
            end
        end
    end
endtask

task automatic read_prom(input prom_sel_t sel, input prom_addr_t addr, output prom_data_t data);
    prom_sel  = sel;
    prom_addr = addr;
    next_cycle();               // Registered read
    data = prom_data;
endtask

task automatic check_after_reset();
    if (soft_rst !== 1'b0 || fetch_ok !== 1'b0 || fetch_busy !== 1'b0) begin
        report_mismatch($sformatf("after reset soft_rst=%b fetch_ok=%b fetch_busy=%b",
                                  soft_rst, fetch_ok, fetch_busy));
    end
endtask

task automatic load_and_read_memory();
    int        i;
    int        cycles;
    logic      ok;
    rom_addr_t a;
    rom_data_t d;
    rom_data_t got;
    start_download();
    for (i = 0; i < 64; i++) begin
        a = MEM_BASE + rom_addr_t'(i);
        d = next_word();
        exp_mem[a] = d;
        write_word(a, d);
    end
    end_download();
    for (i = 0; i < 64; i++) begin
        a = MEM_BASE + rom_addr_t'(i);
        fetch_word(a, got, cycles, ok);
        if (ok && got !== exp_mem[a]) begin
            report_mismatch($sformatf("fetch 0x%h gave 0x%h, expected 0x%h", a, got, exp_mem[a]));
        end
        if (ok && cycles != 3) begin
            report_mismatch($sformatf("fetch 0x%h took %0d cycles, expected 3", a, cycles));
        end
    end
endtask

task automatic load_and_read_proms();
    int         k;
    int         i;
    prom_addr_t a;
    rom_data_t  d;
    prom_data_t got;
    start_download();
    for (k = 0; k < NUM_PROMS; k++) begin
        for (i = 0; i < 16; i++) begin
            a = prom_addr_t'(i * 29 + k * 3);
            d = next_word();
            exp_prom[k][a] = d[3:0];
            write_word(rom_addr_t'(PROM_START + k * 256 + a), d);
        end
    end
    // Just past the last PROM, must change nothing
    for (i = 0; i < 4; i++) begin
        a = prom_addr_t'(i * 29);
        write_word(rom_addr_t'(PROM_START + NUM_PROMS * 256 + a), {12'h000, ~exp_prom[0][a]});
    end
    end_download();
    for (k = 0; k < NUM_PROMS; k++) begin
        for (i = 0; i < 16; i++) begin
            a = prom_addr_t'(i * 29 + k * 3);
            read_prom(prom_sel_t'(k), a, got);
            if (got !== exp_prom[k][a]) begin
                report_mismatch($sformatf("PROM %0d entry 0x%h read 0x%h, expected 0x%h",
                                          k, a, got, exp_prom[k][a]));
            end
        end
    end
endtask

task automatic fetch_under_load();
    int        i;
    int        cycles;
    logic      ok;
    rom_addr_t a;
    rom_addr_t probe;
    rom_data_t d;
    rom_data_t got;
    probe = MEM_BASE + 16'd5;   // Written by the memory test
    start_download();
    fork
        begin
            for (i = 0; i < 32; i++) begin
                a = STREAM_BASE + rom_addr_t'(i);
                d = next_word();
                exp_mem[a] = d;
                write_word(a, d);
            end
        end
        begin
            repeat (4) next_cycle();
            fetch_word(probe, got, cycles, ok);
        end
    join
    end_download();
    if (ok && got !== exp_mem[probe]) begin
        report_mismatch($sformatf("fetch 0x%h under load gave 0x%h, expected 0x%h",
                                  probe, got, exp_mem[probe]));
    end
    if (ok && cycles <= 3) begin
        report_mismatch($sformatf("fetch under load took only %0d cycles", cycles));
    end
    for (i = 0; i < 32; i++) begin
        a = STREAM_BASE + rom_addr_t'(i);
        fetch_word(a, got, cycles, ok);
        if (ok && got !== exp_mem[a]) begin
            report_mismatch($sformatf("streamed 0x%h read 0x%h, expected 0x%h", a, got, exp_mem[a]));
        end
    end
endtask

task automatic soft_reset_sequence();
    int high_cycles;
    rst_req = 1'b0;
    start_download();
    write_word(16'h0123, next_word());
    end_download();
    high_cycles = 0;
    next_cycle();               // Falling edge of downloading seen
    while (soft_rst && high_cycles < SOFT_RST_CYCLES + 8) begin
        high_cycles++;
        next_cycle();
    end
    if (soft_rst) begin
        report_timeout("soft_rst to fall after the download");
    end else if (high_cycles != SOFT_RST_CYCLES) begin
        report_mismatch($sformatf("soft_rst high for %0d cycles, expected %0d",
                                  high_cycles, SOFT_RST_CYCLES));
    end
    rst_req = 1'b1;
    repeat (3) begin
        next_cycle();
        if (soft_rst !== 1'b1) begin
            report_mismatch("soft_rst did not follow rst_req high");
        end
    end
    rst_req = 1'b0;
    next_cycle();
    if (soft_rst !== 1'b0) begin
        report_mismatch("soft_rst did not follow rst_req low");
    end
endtask

initial begin
    clk          = 1'b0;
    rst          = 1'b1;
    downloading  = 1'b0;
    romload_wr   = 1'b0;
    romload_addr = '0;
    romload_data = '0;
    rst_req      = 1'b0;
    fetch_req    = 1'b0;
    fetch_addr   = '0;
    prom_sel     = '0;
    prom_addr    = '0;
    errors       = 0;
    timeouts     = 0;
    rand_state   = 32'hae09_bf5e;
    drive_reset();
    check_after_reset();
    load_and_read_memory();
    load_and_read_proms();
    fetch_under_load();
    soft_reset_sequence();
    $display("Finished with %0d errors and %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
        $display("Everything OK");
    end else begin
        $display("Something failed");
    end
    $finish;
end

endmodule

// ==== logic/arcade_mem_top.sv ====
`timescale 1ns/1ns
// ROM loading and memory sharing subsystem, instantiated by the board wrapper next to the game
module arcade_mem_top import arcade_pkg::*; #(
    parameter int        MEM_WORDS       = 4096,
    parameter rom_addr_t PROM_START      = 16'h1000,
    parameter int        NUM_PROMS       = 4,
    parameter int        SOFT_RST_CYCLES = 255
) (
    input  logic       clk,
    input  logic       rst,
    // Download stream
    input  logic       downloading,
    input  logic       romload_wr,
    input  rom_addr_t  romload_addr,
    input  rom_data_t  romload_data,
    input  logic       rst_req,
    output logic       soft_rst,
    // Game fetches
    input  logic       fetch_req,
    input  rom_addr_t  fetch_addr,
    output rom_data_t  fetch_data,
    output logic       fetch_ok,
    output logic       fetch_busy,
    // Colour PROMs
    input  prom_sel_t  prom_sel,
    input  prom_addr_t prom_addr,
    output prom_data_t prom_data
);

logic                 load_req, load_grant;
logic                 fetch_mem_req_valid, fetch_grant;
logic                 mem_valid, fetch_rd_valid;
mem_req_t             load_mem_req, fetch_mem_req, mem_req;
rom_data_t            rd_data, fetch_rd_data;
logic [NUM_PROMS-1:0] prom_we;
prom_addr_t           prom_wr_addr;
prom_data_t           prom_wr_data;

download_ctrl #(
    .PROM_START      ( PROM_START      ),
    .NUM_PROMS       ( NUM_PROMS       ),
    .SOFT_RST_CYCLES ( SOFT_RST_CYCLES )
) u_download (
    .clk          ( clk          ),
    .rst          ( rst          ),
    .downloading  ( downloading  ),
    .romload_wr   ( romload_wr   ),
    .romload_addr ( romload_addr ),
    .romload_data ( romload_data ),
    .rst_req      ( rst_req      ),
    .load_grant   ( load_grant   ),
    .load_req     ( load_req     ),
    .load_mem_req ( load_mem_req ),
    .prom_we      ( prom_we      ),
    .prom_wr_addr ( prom_wr_addr ),
    .prom_wr_data ( prom_wr_data ),
    .soft_rst     ( soft_rst     )
);

mem_arbiter u_arbiter (
    .clk                 ( clk                 ),
    .rst                 ( rst                 ),
    .load_req            ( load_req            ),
    .load_mem_req        ( load_mem_req        ),
    .load_grant          ( load_grant          ),
    .fetch_mem_req_valid ( fetch_mem_req_valid ),
    .fetch_mem_req       ( fetch_mem_req       ),
    .fetch_grant         ( fetch_grant         ),
    .fetch_rd_data       ( fetch_rd_data       ),
    .fetch_rd_valid      ( fetch_rd_valid      ),
    .mem_valid           ( mem_valid           ),
    .mem_req             ( mem_req             ),
    .rd_data             ( rd_data             )
);

rom_fetch u_fetch (
    .clk           ( clk                 ),
    .rst           ( rst                 ),
    .fetch_req     ( fetch_req           ),
    .fetch_addr    ( fetch_addr          ),
    .fetch_data    ( fetch_data          ),
    .fetch_ok      ( fetch_ok            ),
    .fetch_busy    ( fetch_busy          ),
    .grant         ( fetch_grant         ),
    .rd_valid      ( fetch_rd_valid      ),
    .rd_data       ( fetch_rd_data       ),
    .mem_req_valid ( fetch_mem_req_valid ),
    .mem_req       ( fetch_mem_req       )
);

rom_store #(.MEM_WORDS(MEM_WORDS)) u_store (
    .clk       ( clk       ),
    .mem_valid ( mem_valid ),
    .mem_req   ( mem_req   ),
    .rd_data   ( rd_data   )
);

prom_bank #(.NUM_PROMS(NUM_PROMS)) u_proms (
    .clk          ( clk          ),
    .prom_we      ( prom_we      ),
    .prom_wr_addr ( prom_wr_addr ),
    .prom_wr_data ( prom_wr_data ),
    .prom_sel     ( prom_sel     ),
    .prom_addr    ( prom_addr    ),
    .prom_data    ( prom_data    )
);

endmodule

// ==== logic/prom_bank.sv ====
`timescale 1ns/1ns
// Bank of 4-bit colour PROMs, written during download and read by the game with registered output
module prom_bank import arcade_pkg::*; #(
    parameter int NUM_PROMS = 4
) (
    input  logic                 clk,
    // Download side
    input  logic [NUM_PROMS-1:0] prom_we,
    input  prom_addr_t           prom_wr_addr,
    input  prom_data_t           prom_wr_data,
    // Game side
    input  prom_sel_t            prom_sel,
    input  prom_addr_t           prom_addr,
    output prom_data_t           prom_data
);

prom_data_t mem [NUM_PROMS][256];

// One strobe per PROM, only one is ever high
always_ff @(posedge clk) begin
    for (int i = 0; i < NUM_PROMS; i++) begin
        if (prom_we[i]) begin
            mem[i][prom_wr_addr] <= prom_wr_data;
        end
    end
end

always_ff @(posedge clk) begin
    if (prom_sel < NUM_PROMS) begin
        prom_data <= mem[prom_sel][prom_addr];
    end else begin
        prom_data <= '0;   // Unfitted PROM reads as zero
    end
end

endmodule

// ==== logic/rom_store.sv ====
`timescale 1ns/1ns
// Synchronous single-port word memory standing in for the SDRAM, one cycle read latency
module rom_store import arcade_pkg::*; #(
    parameter int MEM_WORDS = 4096
) (
    input  logic      clk,
    input  logic      mem_valid,
    input  mem_req_t  mem_req,
    output rom_data_t rd_data
);

localparam int AW = $clog2(MEM_WORDS);

rom_data_t     mem [MEM_WORDS];
logic [AW-1:0] word_addr;

// Upper address bits beyond the depth wrap around
assign word_addr = mem_req.addr[AW-1:0];

// Single port, one access per cycle
always_ff @(posedge clk) begin
    if (mem_valid) begin
        if (mem_req.write) begin
            mem[word_addr] <= mem_req.data;
        end else begin
            rd_data <= mem[word_addr];   // Valid next cycle
        end
    end
end

endmodule

// ==== logic/rom_fetch.sv ====
`timescale 1ns/1ns
// Game-side reader: one fetch pulse in, one word and a done pulse out after arbitration
module rom_fetch import arcade_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    // Game side
    input  logic      fetch_req,
    input  rom_addr_t fetch_addr,
    output rom_data_t fetch_data,
    output logic      fetch_ok,
    output logic      fetch_busy,
    // Arbiter side
    input  logic      grant,
    input  logic      rd_valid,
    input  rom_data_t rd_data,
    output logic      mem_req_valid,
    output mem_req_t  mem_req
);

fetch_state_t state;
rom_addr_t    req_addr;

always_ff @(posedge clk) begin
    if (rst) begin
        state    <= idle;
        fetch_ok <= 1'b0;
    end else begin
        fetch_ok <= 1'b0;
        case (state)
            idle: begin
                if (fetch_req) begin
                    state <= wait_grant;
                end
            end
            wait_grant: begin
                if (grant) begin
                    state <= wait_data;
                end
            end
            wait_data: begin
                if (rd_valid) begin
                    state    <= idle;
                    fetch_ok <= 1'b1;
                end
            end
            default: state <= idle;
        endcase
    end
end

// Address captured only on an accepted pulse
always_ff @(posedge clk) begin
    if (state == idle && fetch_req) begin
        req_addr <= fetch_addr;
    end
end

always_ff @(posedge clk) begin
    if (state == wait_data && rd_valid) begin
        fetch_data <= rd_data;
    end
end

// Request held stable until granted
assign mem_req_valid = (state == wait_grant);
assign mem_req       = '{write: 1'b0, addr: req_addr, data: '0};

assign fetch_busy = (state != idle);  // Falls together with fetch_ok

endmodule

// ==== logic/mem_arbiter.sv ====
`timescale 1ns/1ns
// Fixed-priority arbiter sharing the word memory between the loader and the game fetch unit
module mem_arbiter import arcade_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    // Loader side, always wins
    input  logic      load_req,
    input  mem_req_t  load_mem_req,
    output logic      load_grant,
    // Game fetch side
    input  logic      fetch_mem_req_valid,
    input  mem_req_t  fetch_mem_req,
    output logic      fetch_grant,
    output rom_data_t fetch_rd_data,
    output logic      fetch_rd_valid,
    // Memory side
    output logic      mem_valid,
    output mem_req_t  mem_req,
    input  rom_data_t rd_data
);

logic rd_pending;   // Fetch read issued last cycle

// The loader gets every cycle it asks for
assign load_grant  = load_req;
assign fetch_grant = fetch_mem_req_valid && !load_req;

assign mem_valid = load_req || fetch_mem_req_valid;
assign mem_req   = load_req ? load_mem_req : fetch_mem_req;

// Memory has one cycle of read latency
always_ff @(posedge clk) begin
    if (rst) begin
        rd_pending <= 1'b0;
    end else begin
        rd_pending <= fetch_grant && !fetch_mem_req.write;
    end
end

// Only the fetch unit reads, so the data needs no steering beyond the strobe
assign fetch_rd_valid = rd_pending;
assign fetch_rd_data  = rd_data;

endmodule

// ==== logic/download_ctrl.sv ====
// Splits the download stream into shared memory writes and PROM writes and sequences soft reset
`timescale 1ns/1ns
module download_ctrl import arcade_pkg::*; #(
    parameter rom_addr_t PROM_START      = 16'h1000,
    parameter int        NUM_PROMS       = 4,
    parameter int        SOFT_RST_CYCLES = 255
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 downloading,
    input  logic                 romload_wr,
    input  rom_addr_t            romload_addr,
    input  rom_data_t            romload_data,
    input  logic                 rst_req,
    input  logic                 load_grant,
    output logic                 load_req,
    output mem_req_t             load_mem_req,
    output logic [NUM_PROMS-1:0] prom_we,
    output prom_addr_t           prom_wr_addr,
    output prom_data_t           prom_wr_data,
    output logic                 soft_rst
);

localparam int CNT_W = $clog2(SOFT_RST_CYCLES + 1);

logic             wr_ok;
logic             mem_hit;
logic             prom_hit;
rom_addr_t        prom_offset;      // Address relative to the PROM region
logic [CNT_W-1:0] soft_rst_cnt;
logic             last_downloading;

assign wr_ok       = downloading && romload_wr;  // Strobes outside a download are ignored
assign prom_offset = romload_addr - PROM_START;
assign mem_hit     = wr_ok && (romload_addr < PROM_START);
assign prom_hit    = wr_ok && (romload_addr >= PROM_START) && (prom_offset[15:8] < NUM_PROMS);

// PROM entries are written straight from the stream
assign prom_wr_addr = prom_offset[7:0];
assign prom_wr_data = romload_data[3:0];

genvar k;
generate
    for (k = 0; k < NUM_PROMS; k++) begin : g_prom_we
        assign prom_we[k] = prom_hit && (prom_offset[15:8] == 8'(k));
    end
endgenerate

// Memory words are registered and offered to the arbiter
always_ff @(posedge clk) begin
    if (rst) begin
        load_req <= 1'b0;
    end else if (mem_hit) begin
        load_req <= 1'b1;
    end else if (load_grant) begin
        load_req <= 1'b0;   // Consumed
    end
end

always_ff @(posedge clk) begin
    if (mem_hit) begin
        load_mem_req <= '{write: 1'b1, addr: romload_addr, data: romload_data};
    end
end

// Soft reset held after the download ends, then driven by the reset request
always_ff @(posedge clk) begin
    if (rst) begin
        soft_rst         <= 1'b0;
        soft_rst_cnt     <= '0;
        last_downloading <= 1'b0;
    end else begin
        last_downloading <= downloading;
        if (last_downloading && !downloading) begin
            soft_rst     <= 1'b1;
            soft_rst_cnt <= CNT_W'(SOFT_RST_CYCLES);
        end else if (soft_rst_cnt > 1) begin
            soft_rst_cnt <= soft_rst_cnt - 1'b1;
        end else begin
            soft_rst_cnt <= '0;
            soft_rst     <= rst_req;   // Hold time over
        end
    end
end

endmodule

// ==== logic/arcade_pkg.sv ====
// Shared widths, memory access struct and fetch FSM states, imported by every module of the core
package arcade_pkg;

    // Download space and shared memory
    typedef logic [15:0] rom_addr_t;   // Word address
    typedef logic [15:0] rom_data_t;   // One memory word

    // Colour PROMs
    typedef logic [7:0] prom_addr_t;   // Entry inside one PROM
    typedef logic [3:0] prom_data_t;   // 4-bit entry
    typedef logic [1:0] prom_sel_t;    // Up to four PROMs

    // One access to the shared memory, 33 bits
    typedef struct packed {
        logic      write;  // High for a write, low for a read
        rom_addr_t addr;
        rom_data_t data;   // Only meaningful on writes
    } mem_req_t;

    // Game-side fetch unit
    typedef enum logic [1:0] {
        idle,
        wait_grant,        // Read request held towards the arbiter
        wait_data          // Granted, word comes back next cycle
    } fetch_state_t;

endpackage
